/* Makefile */
# Verilator build and run for the accumulation address looper

TOP = tb_accum_warp_looper
BIN = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a listed source changes
$(BIN): sources.f $(shell cat sources.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

# Pass is decided by the pass message in the simulator output
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* sources.f */
src/looper_pkg.sv
src/offset_stepper.sv
src/stage_fifo.sv
src/address_vectorizer.sv
src/accum_warp_looper.sv
tb/looper_checker.sv
tb/tb_accum_warp_looper.sv

/* src/accum_warp_looper.sv */
`default_nettype none
`timescale 1ns/10ps

module accum_warp_looper #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                                         i_clk,
	input  logic                                         i_arst_n,
	// Command
	input  logic                                         i_cmd_rdy,
	output logic                                         o_cmd_ack,
	input  logic [looper_pkg::WBW-1:0]                   i_bofs_x,
	input  logic [looper_pkg::WBW-1:0]                   i_bofs_y,
	input  logic [looper_pkg::WBW-1:0]                   i_abeg_x,
	input  logic [looper_pkg::WBW-1:0]                   i_abeg_y,
	input  logic [looper_pkg::WBW-1:0]                   i_aend_x,
	input  logic [looper_pkg::WBW-1:0]                   i_aend_y,
	// Configuration, held while a command is in flight
	input  logic [looper_pkg::ABW-1:0]                   i_linear,
	input  logic [looper_pkg::ABW-1:0]                   i_row_stride,
	input  logic [looper_pkg::WBW-1:0]                   i_bound_x,
	input  logic [looper_pkg::WBW-1:0]                   i_bound_y,
	// Address vectors
	output logic                                         o_addr_rdy,
	input  logic                                         i_addr_ack,
	output logic [looper_pkg::VSIZE*looper_pkg::ABW-1:0] o_address,
	output logic [looper_pkg::VSIZE-1:0]                 o_valid,
	output logic                                         o_retire
);

	// Producer to FIFO
	logic                       push_rdy;
	logic                       push_ack;
	logic [looper_pkg::WBW-1:0] push_gy;
	logic [looper_pkg::WBW+1:0] push_gx;
	logic                       push_last;

	// FIFO to consumer
	logic                       pop_rdy;
	logic                       pop_ack;
	logic [looper_pkg::WBW-1:0] pop_gy;
	logic [looper_pkg::WBW+1:0] pop_gx;
	logic                       pop_last;

	// ==========================================================
	// Stages
	// ==========================================================

	offset_stepper u_stepper (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_cmd_rdy(i_cmd_rdy), .o_cmd_ack(o_cmd_ack),
		.i_bofs_x(i_bofs_x), .i_bofs_y(i_bofs_y),
		.i_abeg_x(i_abeg_x), .i_abeg_y(i_abeg_y),
		.i_aend_x(i_aend_x), .i_aend_y(i_aend_y),
		.o_push_rdy(push_rdy), .i_push_ack(push_ack),
		.o_push_gy(push_gy), .o_push_gx(push_gx), .o_push_last(push_last)
	);

	stage_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_push_rdy(push_rdy), .o_push_ack(push_ack),
		.i_push_gy(push_gy), .i_push_gx(push_gx), .i_push_last(push_last),
		.o_pop_rdy(pop_rdy), .i_pop_ack(pop_ack),
		.o_pop_gy(pop_gy), .o_pop_gx(pop_gx), .o_pop_last(pop_last)
	);

	address_vectorizer u_vectorizer (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_pop_rdy(pop_rdy), .o_pop_ack(pop_ack),
		.i_gy(pop_gy), .i_gx(pop_gx), .i_last(pop_last),
		.i_linear(i_linear), .i_row_stride(i_row_stride),
		.i_bound_x(i_bound_x), .i_bound_y(i_bound_y),
		.o_addr_rdy(o_addr_rdy), .i_addr_ack(i_addr_ack),
		.o_address(o_address), .o_valid(o_valid), .o_retire(o_retire)
	);

endmodule

`default_nettype wire

/* src/address_vectorizer.sv */
`default_nettype none
`timescale 1ns/10ps

module address_vectorizer (
	input  logic                                         i_clk,
	input  logic                                         i_arst_n,
	input  logic                                         i_pop_rdy,
	output logic                                         o_pop_ack,
	input  logic [looper_pkg::WBW-1:0]                   i_gy,
	input  logic [looper_pkg::WBW+1:0]                   i_gx,
	input  logic                                         i_last,
	input  logic [looper_pkg::ABW-1:0]                   i_linear,
	input  logic [looper_pkg::ABW-1:0]                   i_row_stride,
	input  logic [looper_pkg::WBW-1:0]                   i_bound_x,
	input  logic [looper_pkg::WBW-1:0]                   i_bound_y,
	output logic                                         o_addr_rdy,
	input  logic                                         i_addr_ack,
	output logic [looper_pkg::VSIZE*looper_pkg::ABW-1:0] o_address,
	output logic [looper_pkg::VSIZE-1:0]                 o_valid,
	output logic                                         o_retire
);

	localparam int AW = looper_pkg::ABW;
	localparam int XW = looper_pkg::WBW + 2;
	localparam int VS = looper_pkg::VSIZE;

	logic [AW-1:0]    row_base;
	logic [AW-1:0]    col_base;
	logic [XW-1:0]    lane_x [VS];
	logic [VS*AW-1:0] lane_addr;
	logic [VS-1:0]    lane_valid;
	logic             row_in;
	logic             load;

	// ==========================================================
	// Lane expansion
	// ==========================================================

	// Row base by multiply-add, wraps at ABW bits
	assign row_base = i_linear + AW'(i_gy) * i_row_stride;
	assign col_base = row_base + AW'(i_gx);
	assign row_in   = (i_gy < i_bound_y);

	always_comb begin
		for (int k = 0; k < VS; k++) begin
			lane_x[k]               = i_gx + XW'(k);
			lane_addr[k*AW +: AW]   = col_base + AW'(k);
			// Column check at WBW+2 bits, no wrap for the offsets in use
			lane_valid[k]           = row_in && (lane_x[k] < XW'(i_bound_x));
		end
	end

	// ==========================================================
	// Output register
	// ==========================================================

	// Pop when empty or when the held vector leaves this cycle
	assign o_pop_ack = i_pop_rdy && (!o_addr_rdy || i_addr_ack);
	assign load      = o_pop_ack;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_addr_rdy <= 1'b0;
			o_retire   <= 1'b0;
		end else if (load) begin
			o_addr_rdy <= 1'b1;
			o_retire   <= i_last;
		end else if (i_addr_ack) begin
			o_addr_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			o_address <= lane_addr;
			o_valid   <= lane_valid;
		end
	end

	a_hold_stable: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		(o_addr_rdy && !i_addr_ack) |=>
			(o_addr_rdy && $stable(o_address) && $stable(o_valid) && $stable(o_retire))
	) else $error("address_vectorizer: output changed while waiting for ack");

endmodule

`default_nettype wire

/* src/looper_pkg.sv */
`default_nettype none

package looper_pkg;

	// ==========================================================
	// Widths
	// ==========================================================

	// Warp offsets, range extents and tensor boundaries
	localparam int WBW = 8;

	// Lane addresses, linear base and row stride
	localparam int ABW = 16;

	// ==========================================================
	// Vector shape
	// ==========================================================

	// Lanes per output vector
	// One warp covers VSIZE consecutive columns
	localparam int VSIZE = 4;

	// ==========================================================
	// Producer FSM
	// ==========================================================

	// ST_IDLE waits for a command, ST_RUN walks the warp range
	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_RUN  = 1'b1
	} stepper_state_e;

endpackage

`default_nettype wire

/* src/offset_stepper.sv */
`default_nettype none
`timescale 1ns/10ps

module offset_stepper (
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	input  logic                       i_cmd_rdy,
	output logic                       o_cmd_ack,
	input  logic [looper_pkg::WBW-1:0] i_bofs_x,
	input  logic [looper_pkg::WBW-1:0] i_bofs_y,
	input  logic [looper_pkg::WBW-1:0] i_abeg_x,
	input  logic [looper_pkg::WBW-1:0] i_abeg_y,
	input  logic [looper_pkg::WBW-1:0] i_aend_x,
	input  logic [looper_pkg::WBW-1:0] i_aend_y,
	output logic                       o_push_rdy,
	input  logic                       i_push_ack,
	output logic [looper_pkg::WBW-1:0] o_push_gy,
	output logic [looper_pkg::WBW+1:0] o_push_gx,
	output logic                       o_push_last
);

	localparam int XW = looper_pkg::WBW + 2;

	looper_pkg::stepper_state_e state;

	// Latched command, abeg_y is only needed at the start
	logic [looper_pkg::WBW-1:0] bofs_x_r;
	logic [looper_pkg::WBW-1:0] bofs_y_r;
	logic [looper_pkg::WBW-1:0] abeg_x_r;
	logic [looper_pkg::WBW-1:0] aend_x_r;
	logic [looper_pkg::WBW-1:0] aend_y_r;

	// Warp offset counters
	logic [looper_pkg::WBW-1:0] ax;
	logic [looper_pkg::WBW-1:0] ay;

	logic [looper_pkg::WBW-1:0] ax_last;
	logic [looper_pkg::WBW-1:0] ay_last;
	logic                       cmd_empty;
	logic                       push_fire;
	logic                       row_end;

	// ==========================================================
	// Handshakes and item fields
	// ==========================================================

	// Empty range is acked and skipped
	assign cmd_empty = (i_aend_x <= i_abeg_x) || (i_aend_y <= i_abeg_y);
	assign o_cmd_ack = i_cmd_rdy && (state == looper_pkg::ST_IDLE);

	assign ax_last = aend_x_r - 1'b1;
	assign ay_last = aend_y_r - 1'b1;
	assign row_end = (ax == ax_last);

	assign o_push_rdy = (state == looper_pkg::ST_RUN);
	assign push_fire  = o_push_rdy && i_push_ack;

	assign o_push_last = row_end && (ay == ay_last);
	assign o_push_gy   = bofs_y_r + ay;
	// Each warp spans VSIZE columns
	assign o_push_gx   = XW'(bofs_x_r) + XW'(ax) * XW'(looper_pkg::VSIZE);

	// ==========================================================
	// FSM and counters
	// ==========================================================

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= looper_pkg::ST_IDLE;
			ax    <= '0;
			ay    <= '0;
		end else begin
			case (state)
				looper_pkg::ST_IDLE: begin
					if (o_cmd_ack && !cmd_empty) begin
						state <= looper_pkg::ST_RUN;
						ax    <= i_abeg_x;
						ay    <= i_abeg_y;
					end
				end
				looper_pkg::ST_RUN: begin
					if (push_fire) begin
						if (o_push_last) begin
							state <= looper_pkg::ST_IDLE;
						end else if (row_end) begin
							ax <= abeg_x_r;
							ay <= ay + 1'b1;
						end else begin
							ax <= ax + 1'b1;
						end
					end
				end
				default: state <= looper_pkg::ST_IDLE;
			endcase
		end
	end

	// Command latch
	always_ff @(posedge i_clk) begin
		if (o_cmd_ack) begin
			bofs_x_r <= i_bofs_x;
			bofs_y_r <= i_bofs_y;
			abeg_x_r <= i_abeg_x;
			aend_x_r <= i_aend_x;
			aend_y_r <= i_aend_y;
		end
	end

	a_ax_in_range: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		(state == looper_pkg::ST_RUN) |-> (ax < aend_x_r)
	) else $error("offset_stepper: ax %0h not below aend_x %0h", ax, aend_x_r);

endmodule

`default_nettype wire

/* src/stage_fifo.sv */
`default_nettype none
`timescale 1ns/10ps

module stage_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                       i_clk,
	input  logic                       i_arst_n,
	input  logic                       i_push_rdy,
	output logic                       o_push_ack,
	input  logic [looper_pkg::WBW-1:0] i_push_gy,
	input  logic [looper_pkg::WBW+1:0] i_push_gx,
	input  logic                       i_push_last,
	output logic                       o_pop_rdy,
	input  logic                       i_pop_ack,
	output logic [looper_pkg::WBW-1:0] o_pop_gy,
	output logic [looper_pkg::WBW+1:0] o_pop_gx,
	output logic                       o_pop_last
);

	localparam int XW    = looper_pkg::WBW + 2;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Item storage
	logic [looper_pkg::WBW-1:0] mem_gy [DEPTH];
	logic [XW-1:0]              mem_gx [DEPTH];
	logic [DEPTH-1:0]           mem_last;

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// ==========================================================
	// Handshakes
	// ==========================================================

	assign o_push_ack = (count != CNT_W'(DEPTH));
	assign o_pop_rdy  = (count != '0);
	assign push       = i_push_rdy && o_push_ack;
	assign pop        = o_pop_rdy && i_pop_ack;

	// Head of the queue is always presented
	assign o_pop_gy   = mem_gy[rd_ptr];
	assign o_pop_gx   = mem_gx[rd_ptr];
	assign o_pop_last = mem_last[rd_ptr];

	// ==========================================================
	// Storage and pointers
	// ==========================================================

	always_ff @(posedge i_clk) begin
		if (push) begin
			mem_gy[wr_ptr]   <= i_push_gy;
			mem_gx[wr_ptr]   <= i_push_gx;
			mem_last[wr_ptr] <= i_push_last;
		end
	end

	// Pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_count_bound: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		count <= CNT_W'(DEPTH)
	) else $error("stage_fifo: count %0d above depth %0d", count, DEPTH);

endmodule

`default_nettype wire

/* tb/looper_checker.sv */
`default_nettype none
`timescale 1ns/10ps

module looper_checker (
	input  logic                                         i_clk,
	input  logic                                         i_arst_n,
	input  logic                                         i_cmd_rdy,
	input  logic                                         i_cmd_ack,
	input  logic [looper_pkg::WBW-1:0]                   i_bofs_x,
	input  logic [looper_pkg::WBW-1:0]                   i_bofs_y,
	input  logic [looper_pkg::WBW-1:0]                   i_abeg_x,
	input  logic [looper_pkg::WBW-1:0]                   i_abeg_y,
	input  logic [looper_pkg::WBW-1:0]                   i_aend_x,
	input  logic [looper_pkg::WBW-1:0]                   i_aend_y,
	input  logic [looper_pkg::ABW-1:0]                   i_linear,
	input  logic [looper_pkg::ABW-1:0]                   i_row_stride,
	input  logic [looper_pkg::WBW-1:0]                   i_bound_x,
	input  logic [looper_pkg::WBW-1:0]                   i_bound_y,
	input  logic                                         i_addr_rdy,
	input  logic                                         i_addr_ack,
	input  logic [looper_pkg::VSIZE*looper_pkg::ABW-1:0] i_address,
	input  logic [looper_pkg::VSIZE-1:0]                 i_valid,
	input  logic                                         i_retire,
	input  logic                                         i_done,
	output int                                           o_errors
);

	localparam int VS = looper_pkg::VSIZE;
	localparam int AW = looper_pkg::ABW;

	// Expected vectors in output order
	logic [VS*AW-1:0] exp_addr [$];
	logic [VS-1:0]    exp_valid [$];
	logic             exp_retire [$];

	int errors    = 0;
	int cmds      = 0;
	int full_cmds = 0;
	int vectors   = 0;
	int retires   = 0;
	bit cmd_seen  = 1'b0;
	bit done_seen = 1'b0;

	// Output sample from the previous cycle used by the hold check
	bit               prev_hold = 1'b0;
	logic [VS*AW-1:0] prev_addr;
	logic [VS-1:0]    prev_valid;
	logic             prev_retire;

	assign o_errors = errors;

	// Row-major walk with ax stepping fastest
	task automatic expand_command();
		int gy;
		int gx;
		int addr;
		logic [VS*AW-1:0] vec;
		logic [VS-1:0] msk;
		for (int ay = int'(i_abeg_y); ay < int'(i_aend_y); ay++) begin
			for (int ax = int'(i_abeg_x); ax < int'(i_aend_x); ax++) begin
				gy = (int'(i_bofs_y) + ay) % (1 << looper_pkg::WBW);
				gx = (int'(i_bofs_x) + ax * VS) % (1 << (looper_pkg::WBW + 2));
				for (int k = 0; k < VS; k++) begin
					addr = int'(i_linear) + gy * int'(i_row_stride) + gx + k;
					vec[k*AW +: AW] = AW'(addr);
					msk[k] = (gx + k < int'(i_bound_x)) && (gy < int'(i_bound_y));
				end
				exp_addr.push_back(vec);
				exp_valid.push_back(msk);
				exp_retire.push_back(ay == int'(i_aend_y) - 1 && ax == int'(i_aend_x) - 1);
			end
		end
	endtask

	task automatic compare_vector();
		logic [VS*AW-1:0] ea;
		logic [VS-1:0] ev;
		logic er;
		if (exp_addr.size() == 0) begin
			$display("Output vector %0d arrived with nothing expected", vectors);
			errors++;
		end else begin
			ea = exp_addr.pop_front();
			ev = exp_valid.pop_front();
			er = exp_retire.pop_front();
			if (i_address !== ea) begin
				$display("Error: o_address expected %h got %h", ea, i_address);
				errors++;
			end
			if (i_valid !== ev) begin
				$display("Error: o_valid expected %h got %h", ev, i_valid);
				errors++;
			end
			if (i_retire !== er) begin
				$display("Error: o_retire expected %h got %h", er, i_retire);
				errors++;
			end
		end
		vectors++;
	endtask

	// Held outputs must match the previous sample until the ack
	task automatic check_hold();
		if (!i_addr_rdy) begin
			$display("o_addr_rdy dropped before the held vector was acked");
			errors++;
		end
		if (i_address !== prev_addr) begin
			$display("Error: o_address changed while held, was %h now %h",
				prev_addr, i_address);
			errors++;
		end
		if (i_valid !== prev_valid) begin
			$display("Error: o_valid changed while held, was %h now %h",
				prev_valid, i_valid);
			errors++;
		end
		if (i_retire !== prev_retire) begin
			$display("Error: o_retire changed while held, was %h now %h",
				prev_retire, i_retire);
			errors++;
		end
	endtask

	// Ports are sampled on the falling edge
	always @(negedge i_clk) begin
		if (!cmd_seen) begin
			if (i_cmd_rdy) begin
				cmd_seen = 1'b1;
			end else if (i_addr_rdy || i_cmd_ack || i_retire) begin
				$display("Outputs went high before any command was given");
				errors++;
			end
		end
		if (prev_hold) begin
			check_hold();
		end
		prev_hold   = i_arst_n && i_addr_rdy && !i_addr_ack;
		prev_addr   = i_address;
		prev_valid  = i_valid;
		prev_retire = i_retire;

		if (i_arst_n && i_cmd_rdy && i_cmd_ack) begin
			cmds++;
			if (i_aend_x != i_abeg_x && i_aend_y != i_abeg_y) begin
				full_cmds++;
			end
			expand_command();
		end
		if (i_arst_n && i_addr_rdy && i_addr_ack) begin
			if (i_retire) begin
				retires++;
			end
			compare_vector();
		end

		if (i_done && !done_seen) begin
			done_seen = 1'b1;
			if (exp_addr.size() != 0) begin
				$display("%0d expected vectors never came out", exp_addr.size());
				errors++;
			end
			if (retires != full_cmds) begin
				$display("Saw %0d retires for %0d non-empty commands", retires, full_cmds);
				errors++;
			end
			$display("Checker: %0d commands, %0d vectors, %0d retires, %0d errors",
				cmds, vectors, retires, errors);
		end
	end

endmodule

`default_nettype wire

/* tb/tb_accum_warp_looper.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_accum_warp_looper;

	localparam int NUM_CMDS       = 60;
	localparam int TIMEOUT_CYCLES = NUM_CMDS * 16 * 4 + 1000;
	localparam int VS             = looper_pkg::VSIZE;
	localparam int AW             = looper_pkg::ABW;
	localparam int WW             = looper_pkg::WBW;

	logic             i_clk;
	logic             i_arst_n;
	logic             i_cmd_rdy;
	logic             o_cmd_ack;
	logic [WW-1:0]    i_bofs_x;
	logic [WW-1:0]    i_bofs_y;
	logic [WW-1:0]    i_abeg_x;
	logic [WW-1:0]    i_abeg_y;
	logic [WW-1:0]    i_aend_x;
	logic [WW-1:0]    i_aend_y;
	logic [AW-1:0]    i_linear;
	logic [AW-1:0]    i_row_stride;
	logic [WW-1:0]    i_bound_x;
	logic [WW-1:0]    i_bound_y;
	logic             o_addr_rdy;
	logic             i_addr_ack;
	logic [VS*AW-1:0] o_address;
	logic [VS-1:0]    o_valid;
	logic             o_retire;
	logic             chk_done;
	int               chk_errors;

	// Non-empty commands sent and retire transfers seen
	int sent    = 0;
	int retired = 0;
	int cycles  = 0;

	accum_warp_looper #(.FIFO_DEPTH(4)) uut (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_cmd_rdy(i_cmd_rdy), .o_cmd_ack(o_cmd_ack),
		.i_bofs_x(i_bofs_x), .i_bofs_y(i_bofs_y),
		.i_abeg_x(i_abeg_x), .i_abeg_y(i_abeg_y),
		.i_aend_x(i_aend_x), .i_aend_y(i_aend_y),
		.i_linear(i_linear), .i_row_stride(i_row_stride),
		.i_bound_x(i_bound_x), .i_bound_y(i_bound_y),
		.o_addr_rdy(o_addr_rdy), .i_addr_ack(i_addr_ack),
		.o_address(o_address), .o_valid(o_valid), .o_retire(o_retire)
	);

	looper_checker u_chk (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_cmd_rdy(i_cmd_rdy), .i_cmd_ack(o_cmd_ack),
		.i_bofs_x(i_bofs_x), .i_bofs_y(i_bofs_y),
		.i_abeg_x(i_abeg_x), .i_abeg_y(i_abeg_y),
		.i_aend_x(i_aend_x), .i_aend_y(i_aend_y),
		.i_linear(i_linear), .i_row_stride(i_row_stride),
		.i_bound_x(i_bound_x), .i_bound_y(i_bound_y),
		.i_addr_rdy(o_addr_rdy), .i_addr_ack(i_addr_ack),
		.i_address(o_address), .i_valid(o_valid), .i_retire(o_retire),
		.i_done(chk_done), .o_errors(chk_errors)
	);

	// ============================================================
	// Clock, retire count and timeout
	// ============================================================

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	always @(negedge i_clk) begin
		if (o_addr_rdy && i_addr_ack && o_retire) begin
			retired++;
		end
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge i_clk);
			cycles++;
		end
		$display("Timeout: run still busy after %0d cycles", cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ============================================================
	// Stimulus
	// ============================================================

	task automatic next_drive_slot();
		@(posedge i_clk);
		#10;
	endtask

	// Config may only change once every earlier command has retired
	task automatic wait_drained();
		while (retired != sent) begin
			next_drive_slot();
		end
		next_drive_slot();
	endtask

	task automatic randomize_config();
		i_linear     = AW'($urandom);
		i_row_stride = AW'($urandom);
		i_bound_x    = WW'($urandom_range(40, 4));
		i_bound_y    = WW'($urandom_range(20, 2));
	endtask

	// Offsets reach past the bounds so some lanes and rows go invalid
	task automatic randomize_command();
		i_bofs_x = WW'($urandom_range(int'(i_bound_x) + 4, 0));
		i_bofs_y = WW'($urandom_range(int'(i_bound_y) + 2, 0));
		i_abeg_x = WW'($urandom_range(3, 0));
		i_abeg_y = WW'($urandom_range(3, 0));
		i_aend_x = i_abeg_x + WW'($urandom_range(3, 0));
		i_aend_y = i_abeg_y + WW'($urandom_range(3, 0));
	endtask

	task automatic issue_command();
		bit got;
		got = 1'b0;
		i_cmd_rdy = 1'b1;
		while (!got) begin
			@(negedge i_clk);
			got = o_cmd_ack;
			next_drive_slot();
		end
		i_cmd_rdy = 1'b0;
		if (i_aend_x != i_abeg_x && i_aend_y != i_abeg_y) begin
			sent++;
		end
	endtask

	// Random back-pressure with about 60 percent ack
	initial begin
		@(posedge i_arst_n);
		forever begin
			next_drive_slot();
			i_addr_ack = ($urandom_range(99, 0) < 60);
		end
	end

	initial begin
		void'($urandom(32'hcfaf_da0d));
		i_arst_n   = 1'b0;
		i_cmd_rdy  = 1'b0;
		i_addr_ack = 1'b0;
		chk_done   = 1'b0;
		randomize_config();
		randomize_command();
		repeat (5) @(posedge i_clk);
		#10;
		i_arst_n = 1'b1;
		repeat (3) next_drive_slot();

		for (int n = 0; n < NUM_CMDS; n++) begin
			// Now and then the config changes between commands
			if (n == 0 || $urandom_range(2, 0) == 0) begin
				wait_drained();
				randomize_config();
			end
			randomize_command();
			issue_command();
		end
		wait_drained();
		repeat (4) next_drive_slot();

		chk_done = 1'b1;
		@(negedge i_clk);
		#1;
		if (chk_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
